//--- mem_settings.svh
/*
 * Width settings shared by the line-fill controller and its testbench.
 * Include in any file that sizes a line, a host beat or an address.
 */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Full cache line
`define MEM_LINE_BITS 64

// Host data bus carries half a line per beat
`define MEM_BEAT_BITS 32

// Raw, offset and host addresses
`define MEM_ADDR_BITS 32

// Beats per line and width of the beat counter
`define MEM_BEATS 2
`define MEM_BEAT_IDX_BITS 1

`endif

//--- mem_pkg.sv
/*
 * Opcode and sequencer state types for the line-fill controller.
 * Imported by the RTL blocks and by the testbench.
 */
package mem_pkg;

	// Encoding as driven by the cache miss handler
	typedef enum logic [1:0] {
		OP_IDLE  = 2'b00,
		OP_READ  = 2'b01,
		OP_WRITE = 2'b11
	} mem_op_e;

	// Sequencer states
	typedef enum logic [1:0] {
		ST_STARTUP = 2'b00,
		ST_READY   = 2'b01,
		ST_HOSTOP  = 2'b10,
		ST_FILL    = 2'b11
	} ctrl_state_e;

endpackage

//--- ctrl_req_if.sv
/*
 * Latched cache request from the intake to the sequencer, plus the
 * completion pulse and read line going back.
 */
`include "mem_settings.svh"

interface ctrl_req_if import mem_pkg::*; ();

	// One-cycle launch of a host transfer
	logic start;
	mem_op_e op;
	logic [`MEM_ADDR_BITS-1:0] raw_addr;
	logic [`MEM_LINE_BITS-1:0] wline;

	// Pulses with the last beat
	logic done;
	logic [`MEM_LINE_BITS-1:0] rline;

	modport intake (
		output start, op, raw_addr, wline,
		input  done, rline
	);

	modport ctrl (
		input  start, op, raw_addr, wline,
		output done, rline
	);

endinterface

//--- host_cmd_if.sv
/*
 * Command path between the sequencer and the host port.
 * Go and beat controls run down, grant and the assembled read line come back.
 */
`include "mem_settings.svh"

interface host_cmd_if ();

	// Held through the host phase
	logic rgo;
	logic wgo;

	// One per fill cycle, lower half first
	logic beat_en;
	logic [`MEM_BEAT_IDX_BITS-1:0] beat_idx;

	// Uncorrected address and line to write
	logic [`MEM_ADDR_BITS-1:0] addr;
	logic [`MEM_LINE_BITS-1:0] wline;

	// Host accepted the command
	logic grant;
	logic [`MEM_LINE_BITS-1:0] rline;

	modport ctrl (
		output rgo, wgo, beat_en, beat_idx, addr, wline,
		input  grant, rline
	);

	modport port (
		input  rgo, wgo, beat_en, beat_idx, addr, wline,
		output grant, rline
	);

endinterface

//--- req_intake.sv
/*
 * Four-phase req/ack endpoint toward the cache miss handler.
 * Latches one command, launches it on the sequencer and holds ack until req drops.
 */
`include "mem_settings.svh"

module req_intake import mem_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic ready,
	input  logic req,
	input  mem_op_e op,
	input  logic [`MEM_ADDR_BITS-1:0] raw_address,
	input  logic [`MEM_LINE_BITS-1:0] wdata,
	output logic ack,
	output logic [`MEM_LINE_BITS-1:0] rdata,
	ctrl_req_if.intake creq
);

	typedef enum logic [1:0] {
		IN_IDLE,
		IN_BUSY,
		IN_ACK
	} intake_state_e;

	intake_state_e state;
	logic start_q;
	mem_op_e op_q;
	logic [`MEM_ADDR_BITS-1:0] addr_q;
	logic [`MEM_LINE_BITS-1:0] wline_q;
	logic accept;
	logic host_op;

	// New request only once the controller is up and the last ack is gone
	assign accept = (state == IN_IDLE) && ready && req && !ack;
	// Anything other than read or write never reaches the host
	assign host_op = (op == OP_READ) || (op == OP_WRITE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IN_IDLE;
			start_q <= 1'b0;
			op_q <= OP_IDLE;
			ack <= 1'b0;
		end else begin
			start_q <= 1'b0;
			case (state)
				IN_IDLE: begin
					if (accept) begin
						op_q <= op;
						if (host_op) begin
							start_q <= 1'b1;
							state <= IN_BUSY;
						end else begin
							// Idle opcode, ack straight away
							ack <= 1'b1;
							state <= IN_ACK;
						end
					end
				end
				IN_BUSY: begin
					if (creq.done) begin
						ack <= 1'b1;
						state <= IN_ACK;
					end
				end
				IN_ACK: begin
					// Cache may hold req as long as it likes
					if (!req) begin
						ack <= 1'b0;
						state <= IN_IDLE;
					end
				end
				default: state <= IN_IDLE;
			endcase
		end
	end

	// Command and result payload
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= raw_address;
			wline_q <= wdata;
		end
		if (state == IN_BUSY && creq.done)
			rdata <= creq.rline;
	end

	assign creq.start = start_q;
	assign creq.op = op_q;
	assign creq.raw_addr = addr_q;
	assign creq.wline = wline_q;

endmodule

//--- mem_ctrl.sv
/*
 * Transfer sequencer of the line-fill controller.
 * Waits for host init, runs one host command per request and steps
 * through the half-line beats, flagging completion on the last one.
 */
`include "mem_settings.svh"

module mem_ctrl import mem_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic host_init,
	output logic ready,
	output logic tx_done,
	output logic rd_valid,
	ctrl_req_if.ctrl creq,
	host_cmd_if.ctrl hcmd
);

	localparam int unsigned BEAT_W = `MEM_BEAT_IDX_BITS;
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`MEM_BEATS - 1);

	ctrl_state_e state;
	logic [BEAT_W-1:0] beat_cnt;
	logic is_read;
	logic is_write;
	logic last_beat;

	// Op is held steady by the intake for the whole transfer
	assign is_read = (creq.op == OP_READ);
	assign is_write = (creq.op == OP_WRITE);
	assign last_beat = (beat_cnt == LAST_BEAT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_STARTUP;
			beat_cnt <= '0;
		end else begin
			case (state)
				ST_STARTUP: begin
					// Nothing is serviced before the host is up
					if (host_init)
						state <= ST_READY;
				end
				ST_READY: begin
					if (creq.start && (is_read || is_write))
						state <= ST_HOSTOP;
				end
				ST_HOSTOP: begin
					// Host phase lasts as long as the host needs
					if (hcmd.grant) begin
						beat_cnt <= '0;
						state <= ST_FILL;
					end
				end
				ST_FILL: begin
					if (last_beat) begin
						beat_cnt <= '0;
						state <= ST_READY;
					end else begin
						beat_cnt <= beat_cnt + 1'b1;
					end
				end
				default: state <= ST_STARTUP;
			endcase
		end
	end

	always_comb begin
		// Defaults
		ready = 1'b1;
		tx_done = 1'b0;
		rd_valid = 1'b0;
		hcmd.rgo = 1'b0;
		hcmd.wgo = 1'b0;
		hcmd.beat_en = 1'b0;

		case (state)
			ST_STARTUP: begin
				ready = 1'b0;
			end
			ST_READY: begin
			end
			ST_HOSTOP: begin
				// Go stays up until the port grants
				hcmd.rgo = is_read;
				hcmd.wgo = is_write;
			end
			ST_FILL: begin
				hcmd.beat_en = 1'b1;
				rd_valid = is_read;
				// Completion rides on the final beat
				tx_done = last_beat;
			end
			default: begin
				ready = 1'b0;
			end
		endcase
	end

	assign hcmd.beat_idx = beat_cnt;

	// Address correction and beat split happen in the host port
	assign hcmd.addr = creq.raw_addr;
	assign hcmd.wline = creq.wline;

	// Completion and read line back to the intake
	assign creq.done = tx_done;
	assign creq.rline = hcmd.rline;

endmodule

//--- host_port.sv
/*
 * Host DMA side of the line-fill controller.
 * Adds the address offset, grants reads at once and writes after one
 * settling bubble, and moves the line as two half-line beats.
 */
`include "mem_settings.svh"

module host_port (
	input  logic clk,
	input  logic rst_n,
	input  logic [`MEM_ADDR_BITS-1:0] address_offset,
	input  logic host_rd_ready,
	input  logic host_wr_ready,
	input  logic [`MEM_BEAT_BITS-1:0] host_data_bus_read_in,
	output logic [`MEM_ADDR_BITS-1:0] host_address,
	output logic host_rgo,
	output logic host_wgo,
	output logic host_re,
	output logic host_we,
	output logic [`MEM_BEAT_BITS-1:0] host_data_bus_write_out,
	host_cmd_if.port hcmd
);

	localparam int unsigned BB = `MEM_BEAT_BITS;

	logic bubble_q;
	logic wr_dir_q;
	logic [`MEM_LINE_BITS-1:0] line_q;

	// Static offset, wraps at the address width
	assign host_address = hcmd.addr + address_offset;

	assign host_rgo = hcmd.rgo;
	assign host_wgo = hcmd.wgo;

	// Direction remembered from the go phase, beats carry no op
	assign host_re = hcmd.beat_en && !wr_dir_q;
	assign host_we = hcmd.beat_en && wr_dir_q;

	// Reads are granted on ready, writes one bubble later
	assign hcmd.grant = (hcmd.rgo && host_rd_ready) || (hcmd.wgo && bubble_q);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bubble_q <= 1'b0;
			wr_dir_q <= 1'b0;
		end else begin
			// Extra cycle lets the DMA side settle the address
			if (bubble_q)
				bubble_q <= 1'b0;
			else if (hcmd.wgo && host_wr_ready)
				bubble_q <= 1'b1;

			if (hcmd.wgo)
				wr_dir_q <= 1'b1;
			else if (hcmd.rgo)
				wr_dir_q <= 1'b0;
		end
	end

	// Write half picked by beat index
	assign host_data_bus_write_out = hcmd.wline[hcmd.beat_idx*BB +: BB];

	// Read beats land in their half of the line
	always_ff @(posedge clk) begin
		if (host_re)
			line_q[hcmd.beat_idx*BB +: BB] <= host_data_bus_read_in;
	end

	// Current beat bypasses the register so the line is whole at done
	always_comb begin
		hcmd.rline = line_q;
		if (host_re)
			hcmd.rline[hcmd.beat_idx*BB +: BB] = host_data_bus_read_in;
	end

endmodule

//--- mem_subsys_top.sv
/*
 * Top level of the line-fill memory controller.
 * Cache, configuration and host DMA signals enter as plain ports.
 */
`include "mem_settings.svh"

module mem_subsys_top import mem_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	// Cache side
	input  logic req,
	input  mem_op_e op,
	input  logic [`MEM_ADDR_BITS-1:0] raw_address,
	input  logic [`MEM_LINE_BITS-1:0] wdata,
	output logic ack,
	output logic [`MEM_LINE_BITS-1:0] rdata,
	// Configuration
	input  logic host_init,
	input  logic [`MEM_ADDR_BITS-1:0] address_offset,
	// Host DMA port
	input  logic host_rd_ready,
	input  logic host_wr_ready,
	input  logic [`MEM_BEAT_BITS-1:0] host_data_bus_read_in,
	output logic host_rgo,
	output logic host_wgo,
	output logic host_re,
	output logic host_we,
	output logic [`MEM_ADDR_BITS-1:0] host_address,
	output logic [`MEM_BEAT_BITS-1:0] host_data_bus_write_out,
	// Status
	output logic ready,
	output logic tx_done,
	output logic rd_valid
);

	ctrl_req_if creq ();
	host_cmd_if hcmd ();

	req_intake u_intake (
		.clk(clk),
		.rst_n(rst_n),
		.ready(ready),
		.req(req),
		.op(op),
		.raw_address(raw_address),
		.wdata(wdata),
		.ack(ack),
		.rdata(rdata),
		.creq(creq.intake)
	);

	mem_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.host_init(host_init),
		.ready(ready),
		.tx_done(tx_done),
		.rd_valid(rd_valid),
		.creq(creq.ctrl),
		.hcmd(hcmd.ctrl)
	);

	host_port u_port (
		.clk(clk),
		.rst_n(rst_n),
		.address_offset(address_offset),
		.host_rd_ready(host_rd_ready),
		.host_wr_ready(host_wr_ready),
		.host_data_bus_read_in(host_data_bus_read_in),
		.host_address(host_address),
		.host_rgo(host_rgo),
		.host_wgo(host_wgo),
		.host_re(host_re),
		.host_we(host_we),
		.host_data_bus_write_out(host_data_bus_write_out),
		.hcmd(hcmd.port)
	);

endmodule

//--- host_mem_model.sv
/*
 * Host DMA memory for the line-fill controller testbench.
 * Answers host go after a random delay, serves and stores half-line beats,
 * and keeps the last host address and a count of host commands.
 */
`include "mem_settings.svh"

module host_mem_model (
	input  logic clk,
	input  logic rst_n,
	input  logic host_rgo,
	input  logic host_wgo,
	input  logic host_re,
	input  logic host_we,
	input  logic [`MEM_ADDR_BITS-1:0] host_address,
	input  logic [`MEM_BEAT_BITS-1:0] host_data_bus_write_out,
	output logic host_rd_ready,
	output logic host_wr_ready,
	output logic [`MEM_BEAT_BITS-1:0] host_data_bus_read_in
);
	timeunit 1ns;
	timeprecision 100ps;

	// Sparse beat store, key is host address with the beat index below it
	logic [`MEM_BEAT_BITS-1:0] mem [logic [`MEM_ADDR_BITS:0]];
	logic [`MEM_ADDR_BITS-1:0] last_address;
	int go_count;

	// Unwritten beats read back a pattern of the full address
	function automatic logic [`MEM_BEAT_BITS-1:0] peek_beat(
		input logic [`MEM_ADDR_BITS-1:0] addr,
		input logic beat
	);
		logic [`MEM_ADDR_BITS:0] key;
		key = {addr, beat};
		if (mem.exists(key))
			return mem[key];
		return {addr[15:0], addr[31:16]} ^ {beat, 31'h1357_9bdf};
	endfunction

	task automatic preload_line(
		input logic [`MEM_ADDR_BITS-1:0] addr,
		input logic [`MEM_LINE_BITS-1:0] line
	);
		mem[{addr, 1'b0}] = line[`MEM_BEAT_BITS-1:0];
		mem[{addr, 1'b1}] = line[`MEM_LINE_BITS-1:`MEM_BEAT_BITS];
	endtask

	// Command phase, ready held for one cycle after a random wait
	initial begin
		int unsigned delay;
		host_rd_ready = 1'b0;
		host_wr_ready = 1'b0;
		last_address = '0;
		go_count = 0;
		forever begin
			@(posedge clk);
			#10;
			if (rst_n && (host_rgo || host_wgo)) begin
				last_address = host_address;
				go_count++;
				delay = $urandom_range(5, 0);
				repeat (delay) begin
					@(posedge clk);
					#10;
				end
				if (host_rgo)
					host_rd_ready = 1'b1;
				else
					host_wr_ready = 1'b1;
				@(posedge clk);
				#10;
				host_rd_ready = 1'b0;
				host_wr_ready = 1'b0;
			end
		end
	end

	// Beat phase, lower half first in both directions
	initial begin
		logic rd_beat;
		logic wr_beat;
		rd_beat = 1'b0;
		wr_beat = 1'b0;
		host_data_bus_read_in = '0;
		forever begin
			@(posedge clk);
			#10;
			if (host_re) begin
				host_data_bus_read_in = peek_beat(host_address, rd_beat);
				rd_beat = !rd_beat;
			end else begin
				rd_beat = 1'b0;
			end
			if (host_we) begin
				mem[{host_address, wr_beat}] = host_data_bus_write_out;
				wr_beat = !wr_beat;
			end else begin
				wr_beat = 1'b0;
			end
		end
	end

endmodule

//--- tb_mem_subsys.sv
/*
 * Testbench for the line-fill memory controller.
 * Drives random cache requests through the four-phase handshake and checks
 * read lines, written beats and corrected host addresses against a line model.
 */
`include "mem_settings.svh"

module tb_mem_subsys import mem_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic rst_n;
	logic req;
	mem_op_e op;
	logic [`MEM_ADDR_BITS-1:0] raw_address;
	logic [`MEM_LINE_BITS-1:0] wdata;
	logic ack;
	logic [`MEM_LINE_BITS-1:0] rdata;
	logic host_init;
	logic [`MEM_ADDR_BITS-1:0] address_offset;
	logic host_rd_ready;
	logic host_wr_ready;
	logic [`MEM_BEAT_BITS-1:0] host_data_bus_read_in;
	logic host_rgo;
	logic host_wgo;
	logic host_re;
	logic host_we;
	logic [`MEM_ADDR_BITS-1:0] host_address;
	logic [`MEM_BEAT_BITS-1:0] host_data_bus_write_out;
	logic ready;
	logic tx_done;
	logic rd_valid;

	// Reference lines by corrected address
	logic [`MEM_LINE_BITS-1:0] ref_mem [logic [`MEM_ADDR_BITS-1:0]];
	logic [`MEM_ADDR_BITS-1:0] corr_tbl [16];
	int error_count;
	int check_count;

	// Strobe cycles seen since the current exchange began
	int rd_valid_seen;
	int re_seen;
	int we_seen;
	int done_seen;
	int done_last_seen;

	mem_subsys_top uut (
		.clk(clk), .rst_n(rst_n),
		.req(req), .op(op), .raw_address(raw_address), .wdata(wdata),
		.ack(ack), .rdata(rdata),
		.host_init(host_init), .address_offset(address_offset),
		.host_rd_ready(host_rd_ready), .host_wr_ready(host_wr_ready),
		.host_data_bus_read_in(host_data_bus_read_in),
		.host_rgo(host_rgo), .host_wgo(host_wgo), .host_re(host_re), .host_we(host_we),
		.host_address(host_address), .host_data_bus_write_out(host_data_bus_write_out),
		.ready(ready), .tx_done(tx_done), .rd_valid(rd_valid)
	);

	host_mem_model host (
		.clk(clk), .rst_n(rst_n),
		.host_rgo(host_rgo), .host_wgo(host_wgo), .host_re(host_re), .host_we(host_we),
		.host_address(host_address), .host_data_bus_write_out(host_data_bus_write_out),
		.host_rd_ready(host_rd_ready), .host_wr_ready(host_wr_ready),
		.host_data_bus_read_in(host_data_bus_read_in)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Output strobes sampled mid-cycle, where the DUT outputs are settled
	initial begin
		logic beat_now;
		logic beat_prev;
		beat_prev = 1'b0;
		forever begin
			@(negedge clk);
			beat_now = (host_re === 1'b1) || (host_we === 1'b1);
			if (rd_valid === 1'b1)
				rd_valid_seen++;
			if (host_re === 1'b1)
				re_seen++;
			if (host_we === 1'b1)
				we_seen++;
			if (tx_done === 1'b1)
				done_seen++;
			// Completion belongs with the second of two back-to-back beats
			if (tx_done === 1'b1 && beat_now && beat_prev)
				done_last_seen++;
			beat_prev = beat_now;
		end
	end

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s at %0t", reason, $time);
		$display("Test failed");
		$finish;
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("test %-16s %0d errors", name, error_count - errors_before);
	endtask

	// Beats and completions expected for one exchange
	task automatic check_activity(input int rd_beats, input int wr_beats, input int dones);
		check_value("rd_valid cycles", 64'(rd_valid_seen), 64'(rd_beats));
		check_value("host_re cycles", 64'(re_seen), 64'(rd_beats));
		check_value("host_we cycles", 64'(we_seen), 64'(wr_beats));
		check_value("tx_done cycles", 64'(done_seen), 64'(dones));
		check_value("tx_done on last beat", 64'(done_last_seen), 64'(dones));
	endtask

	// Every step lands 10 ns after a rising edge
	task automatic wait_for_ack(input logic level, input int limit, output bit seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < limit) begin
			@(posedge clk);
			#10;
			cycles++;
			if (ack === level)
				seen = 1'b1;
		end
	endtask

	// One full four-phase exchange, req held a random time after ack
	task automatic cache_xfer(input mem_op_e xop, input logic [31:0] addr,
		input logic [63:0] line, input int max_gap, output logic [63:0] line_out);
		bit seen;
		int gap;
		int go_before;
		logic [31:0] corr;
		go_before = host.go_count;
		corr = addr + address_offset;
		rd_valid_seen = 0;
		re_seen = 0;
		we_seen = 0;
		done_seen = 0;
		done_last_seen = 0;
		op = xop;
		raw_address = addr;
		wdata = line;
		req = 1'b1;
		wait_for_ack(1'b1, 60, seen);
		if (!seen)
			abort_run($sformatf("No ack for request at raw address %h", addr));
		line_out = rdata;
		gap = $urandom_range(max_gap, 0);
		repeat (gap) begin
			@(posedge clk);
			#10;
			check_value("ack", 64'(ack), 64'd1);
		end
		req = 1'b0;
		// Release comes one cycle after req drops
		@(posedge clk);
		#10;
		check_value("ack", 64'(ack), 64'd0);
		if (xop == OP_IDLE) begin
			check_value("host command count", 64'(host.go_count), 64'(go_before));
			check_activity(0, 0, 0);
		end else begin
			check_value("host command count", 64'(host.go_count), 64'(go_before + 1));
			check_value("host_address", 64'(host.last_address), 64'(corr));
			if (xop == OP_READ)
				check_activity(`MEM_BEATS, 0, 1);
			else
				check_activity(0, `MEM_BEATS, 1);
		end
	endtask

	// Raw address chosen so the corrected one hits a preloaded line
	task automatic read_preloaded(input int max_gap);
		int idx;
		logic [31:0] raw;
		logic [63:0] got;
		idx = $urandom_range(15, 0);
		raw = corr_tbl[idx] - address_offset;
		cache_xfer(OP_READ, raw, {$urandom, $urandom}, max_gap, got);
		check_value("rdata", got, ref_mem[corr_tbl[idx]]);
	endtask

	task automatic write_line(input logic [31:0] raw, input logic [63:0] line, input int max_gap);
		logic [31:0] corr;
		logic [63:0] unused_line;
		corr = raw + address_offset;
		cache_xfer(OP_WRITE, raw, line, max_gap, unused_line);
		ref_mem[corr] = line;
		check_value("host beat 0", 64'(host.peek_beat(corr, 1'b0)), 64'(line[31:0]));
		check_value("host beat 1", 64'(host.peek_beat(corr, 1'b1)), 64'(line[63:32]));
	endtask

	initial begin
		bit seen;
		int cycles;
		int errors_before;
		logic [31:0] raw;
		logic [63:0] line;
		logic [63:0] got;
		void'($urandom(32'hd811));
		error_count = 0;
		check_count = 0;
		rd_valid_seen = 0;
		re_seen = 0;
		we_seen = 0;
		done_seen = 0;
		done_last_seen = 0;
		rst_n = 1'b0;
		req = 1'b0;
		op = OP_IDLE;
		raw_address = '0;
		wdata = '0;
		host_init = 1'b0;
		address_offset = '0;
		repeat (10) @(posedge clk);
		#10;
		rst_n = 1'b1;

		// Startup, nothing accepted before host init
		errors_before = error_count;
		check_value("ready", 64'(ready), 64'd0);
		check_value("ack", 64'(ack), 64'd0);
		check_value("tx_done", 64'(tx_done), 64'd0);
		check_value("rd_valid", 64'(rd_valid), 64'd0);
		check_value("host go", 64'({host_rgo, host_wgo}), 64'd0);
		check_value("host beat enables", 64'({host_re, host_we}), 64'd0);
		op = OP_READ;
		raw_address = 32'h0000_1240;
		req = 1'b1;
		wait_for_ack(1'b1, 20, seen);
		check_value("ack seen before init", 64'(seen), 64'd0);
		check_value("ready", 64'(ready), 64'd0);
		check_value("host command count", 64'(host.go_count), 64'd0);
		req = 1'b0;
		host_init = 1'b1;
		cycles = 0;
		while (ready !== 1'b1 && cycles < 10) begin
			@(posedge clk);
			#10;
			cycles++;
		end
		if (ready !== 1'b1)
			abort_run("ready did not rise after host_init was driven high");
		else
			check_value("cycles from host_init to ready", 64'(cycles), 64'd1);
		report_test("startup", errors_before);

		// Preloaded lines in host memory and in the model
		for (int i = 0; i < 16; i++) begin
			corr_tbl[i] = $urandom;
			line = {$urandom, $urandom};
			host.preload_line(corr_tbl[i], line);
			ref_mem[corr_tbl[i]] = line;
		end

		errors_before = error_count;
		address_offset = $urandom;
		for (int i = 0; i < 40; i++)
			read_preloaded(3);
		report_test("reads", errors_before);

		// Offset is kept within each write and readback pair
		errors_before = error_count;
		for (int i = 0; i < 20; i++) begin
			address_offset = $urandom;
			raw = $urandom;
			write_line(raw, {$urandom, $urandom}, 3);
			cache_xfer(OP_READ, raw, '0, 3, got);
			check_value("readback rdata", got, ref_mem[raw + address_offset]);
		end
		report_test("write readback", errors_before);

		// New offset per request, sums often wrap
		errors_before = error_count;
		for (int i = 0; i < 20; i++) begin
			address_offset = (i % 4 == 0) ? 32'hffff_ff00 | 32'($urandom_range(255, 0)) : $urandom;
			read_preloaded(2);
		end
		report_test("address offset", errors_before);

		// Mixed traffic, long req hold and idle opcodes
		errors_before = error_count;
		for (int i = 0; i < 30; i++) begin
			case ($urandom_range(2, 0))
				0: cache_xfer(OP_IDLE, $urandom, {$urandom, $urandom}, 6, got);
				1: read_preloaded(6);
				default: write_line($urandom, {$urandom, $urandom}, 6);
			endcase
		end
		report_test("handshake", errors_before);

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- mem_subsys.f
+incdir+.
mem_pkg.sv
ctrl_req_if.sv
host_cmd_if.sv
req_intake.sv
mem_ctrl.sv
host_port.sv
mem_subsys_top.sv
host_mem_model.sv
tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -f mem_subsys.f --top-module tb_mem_subsys -o tb_mem_subsys \
	&& ./obj_dir/tb_mem_subsys | tee sim.log \
	|| { echo "Build or simulation run did not complete"; exit 1; }

grep -q "Test completed successfully" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }
